// ==== simd_div_slice.f ====
source/simd_div_pkg.sv
source/simd_div_ctrl.sv
source/iter_counter.sv
source/lane_slicer.sv
source/div_lane.sv
source/result_packer.sv
source/simd_div_slice.sv
verification/simd_div_slice_tb.sv

// ==== source/div_lane.sv ====
// Restoring unsigned divider lane that yields one quotient bit per step
`timescale 1ns/1ns
`default_nettype none

module div_lane #(
  parameter int unsigned LaneWidth = 32
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 start_i,
  input  logic                                 step_i,
  input  logic [simd_div_pkg::SLICE_WIDTH-1:0] dividend_i,
  input  logic [simd_div_pkg::SLICE_WIDTH-1:0] divisor_i,
  output logic [LaneWidth-1:0]                 quotient_o,
  output logic [LaneWidth-1:0]                 remainder_o,
  output logic                                 div_zero_o
);

  logic [LaneWidth-1:0] rem_q;
  logic [LaneWidth-1:0] quo_q;
  logic [LaneWidth-1:0] dvd_q;
  logic [LaneWidth-1:0] dvs_q;
  logic                 dz_q;

  // Partial remainder with the next dividend bit shifted in
  logic [LaneWidth:0]   shifted;
  logic [LaneWidth-1:0] diff;
  logic                 fits;

  // ----------------------------------------------------------
  // Trial subtraction
  // ----------------------------------------------------------
  assign shifted = {rem_q, dvd_q[LaneWidth-1]};
  assign fits    = (shifted >= {1'b0, dvs_q});
  // A fitting trial leaves less than the divisor, so LaneWidth bits suffice
  assign diff    = shifted[LaneWidth-1:0] - dvs_q;

  // ----------------------------------------------------------
  // Datapath registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rem_q <= '0;
      quo_q <= '0;
      dvd_q <= dividend_i[LaneWidth-1:0];
      dvs_q <= divisor_i[LaneWidth-1:0];
    end else if (step_i) begin
      // With a zero divisor every trial fits, so the quotient fills with ones
      if (fits) begin
        rem_q <= diff;
      end else begin
        rem_q <= shifted[LaneWidth-1:0];
      end
      quo_q <= {quo_q[LaneWidth-2:0], fits};
      dvd_q <= dvd_q << 1;
    end
  end

  // Divide-by-zero flag
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dz_q <= 1'b0;
    end else if (start_i) begin
      dz_q <= (divisor_i[LaneWidth-1:0] == '0);
    end
  end

  assign quotient_o  = quo_q;
  assign remainder_o = rem_q;
  assign div_zero_o  = dz_q;

endmodule

`default_nettype wire

// ==== source/iter_counter.sv ====
// Down-counter of divider iterations that flags the final step
`timescale 1ns/1ns
`default_nettype none

module iter_counter (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   start_i,
  input  logic                   step_i,
  input  simd_div_pkg::int_fmt_e fmt_i,
  output logic                   last_step_o
);

  import simd_div_pkg::*;

  logic [CNT_WIDTH-1:0] cnt_q;

  // One iteration per element bit, so the format sets the latency
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CNT_WIDTH'(fmt_width(fmt_i));
    end else if (step_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign last_step_o = (cnt_q == CNT_WIDTH'(1));

endmodule

`default_nettype wire

// ==== source/lane_slicer.sv ====
// Cuts the operand words into per-lane dividends and divisors
`timescale 1ns/1ns
`default_nettype none

module lane_slicer (
  input  logic [simd_div_pkg::SLICE_WIDTH-1:0]                          operand_a_i,
  input  logic [simd_div_pkg::SLICE_WIDTH-1:0]                          operand_b_i,
  input  simd_div_pkg::int_fmt_e                                        fmt_i,
  input  logic                                                          vectorial_i,
  output logic [simd_div_pkg::NUM_LANES-1:0][simd_div_pkg::SLICE_WIDTH-1:0] lane_dividend_o,
  output logic [simd_div_pkg::NUM_LANES-1:0][simd_div_pkg::SLICE_WIDTH-1:0] lane_divisor_o,
  output logic [simd_div_pkg::NUM_LANES-1:0]                            lane_active_o
);

  import simd_div_pkg::*;

  always_comb begin
    int unsigned            w;
    int unsigned            lw;
    logic [SLICE_WIDTH-1:0] field_mask;
    logic [SLICE_WIDTH-1:0] a_field;
    logic [SLICE_WIDTH-1:0] b_field;

    w          = fmt_width(fmt_i);
    field_mask = {SLICE_WIDTH{1'b1}} >> (SLICE_WIDTH - w);

    for (int i = 0; i < NUM_LANES; i++) begin
      lw      = LANE_WIDTHS[i];
      a_field = (operand_a_i >> (i * w)) & field_mask;
      b_field = (operand_b_i >> (i * w)) & field_mask;

      // Dividend sits at the top of the lane so W steps shift it out MSB first
      if (w <= lw) begin
        a_field = a_field << (lw - w);
      end

      lane_dividend_o[i] = a_field;
      lane_divisor_o[i]  = b_field;

      // Scalar requests only ever use lane 0
      if (vectorial_i) begin
        lane_active_o[i] = (i < fmt_lanes(fmt_i));
      end else begin
        lane_active_o[i] = (i == 0);
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/result_packer.sv ====
// Packs lane results into one word and collapses the lane status
`timescale 1ns/1ns
`default_nettype none

module result_packer #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  start_i,
  input  simd_div_pkg::int_fmt_e                fmt_i,
  input  simd_div_pkg::div_op_e                 op_i,
  input  logic [simd_div_pkg::NUM_LANES-1:0]    simd_mask_i,
  input  logic [simd_div_pkg::NUM_LANES-1:0]    lane_active_i,
  input  logic [TagWidth-1:0]                   tag_i,
  input  logic [simd_div_pkg::NUM_LANES-1:0][simd_div_pkg::SLICE_WIDTH-1:0] lane_quotient_i,
  input  logic [simd_div_pkg::NUM_LANES-1:0][simd_div_pkg::SLICE_WIDTH-1:0] lane_remainder_i,
  input  logic [simd_div_pkg::NUM_LANES-1:0]    lane_div_zero_i,
  output logic [simd_div_pkg::SLICE_WIDTH-1:0]  result_o,
  output logic                                  status_dz_o,
  output logic [TagWidth-1:0]                   tag_o
);

  import simd_div_pkg::*;

  int_fmt_e             fmt_q;
  div_op_e              op_q;
  logic [NUM_LANES-1:0] active_q;
  logic [NUM_LANES-1:0] mask_q;
  logic [TagWidth-1:0]  tag_q;

  // ----------------------------------------------------------
  // Request attributes, held for the whole operation
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= '0;
      mask_q   <= '0;
    end else if (start_i) begin
      active_q <= lane_active_i;
      mask_q   <= simd_mask_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      fmt_q <= fmt_i;
      op_q  <= op_i;
      tag_q <= tag_i;
    end
  end

  // ----------------------------------------------------------
  // Result packing
  // ----------------------------------------------------------
  always_comb begin
    int unsigned            w;
    logic [SLICE_WIDTH-1:0] field_mask;
    logic [SLICE_WIDTH-1:0] lane_val;

    w          = fmt_width(fmt_q);
    field_mask = {SLICE_WIDTH{1'b1}} >> (SLICE_WIDTH - w);
    result_o   = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_val = (op_q == REM) ? lane_remainder_i[i] : lane_quotient_i[i];
      // Inactive lanes leave their field at zero
      if (active_q[i]) begin
        result_o = result_o | ((lane_val & field_mask) << (i * w));
      end
    end
  end

  // Only active, unmasked lanes may raise divide-by-zero
  assign status_dz_o = |(lane_div_zero_i & active_q & mask_q);
  assign tag_o       = tag_q;

endmodule

`default_nettype wire

// ==== source/simd_div_ctrl.sv ====
// Handshake and sequencing FSM for the iterative SIMD divide slice
`timescale 1ns/1ns
`default_nettype none

module simd_div_ctrl (
  input  logic clk_i,
  input  logic reset_i,
  input  logic in_valid_i,
  input  logic flush_i,
  input  logic out_ready_i,
  input  logic last_step_i,
  output logic in_ready_o,
  output logic start_o,
  output logic step_o,
  output logic out_valid_o,
  output logic busy_o
);

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } state_e;

  state_e state_q;
  state_e state_d;

  // Set for the one cycle after the final step, lets the lane results settle
  logic drain_q;

  // ----------------------------------------------------------
  // Handshake outputs
  // ----------------------------------------------------------
  // A flush in the same cycle wins over a new request
  assign in_ready_o  = (state_q == IDLE) & ~flush_i;
  assign start_o     = in_valid_i & in_ready_o;
  assign step_o      = (state_q == RUN) & ~drain_q;
  assign out_valid_o = (state_q == DONE);
  assign busy_o      = (state_q != IDLE);

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_o) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (drain_q) begin
          state_d = DONE;
        end
      end
      DONE: begin
        // Result held until the consumer takes it
        if (out_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
    if (flush_i) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      drain_q <= 1'b0;
    end else begin
      state_q <= state_d;
      drain_q <= step_o & last_step_i & ~flush_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/simd_div_pkg.sv ====
// Shared formats, operations and lane geometry of the SIMD divide slice
`default_nettype none

package simd_div_pkg;

  // Integer element formats of a request
  typedef enum logic [1:0] {
    INT8  = 2'd0,
    INT16 = 2'd1,
    INT32 = 2'd2
  } int_fmt_e;

  // Result selection
  typedef enum logic {
    DIV = 1'b0,
    REM = 1'b1
  } div_op_e;

  localparam int unsigned SLICE_WIDTH = 32;
  localparam int unsigned NUM_LANES   = 4;

  // Lane 0 handles every format, the upper lanes only the narrow ones
  localparam int unsigned LANE_WIDTHS [NUM_LANES] = '{32, 16, 8, 8};

  // Wide enough to hold the 32 iterations of INT32
  localparam int unsigned CNT_WIDTH = 6;

  function automatic int unsigned fmt_width(int_fmt_e fmt);
    case (fmt)
      INT8:    return 8;
      INT16:   return 16;
      default: return 32;
    endcase
  endfunction

  function automatic int unsigned fmt_lanes(int_fmt_e fmt);
    case (fmt)
      INT8:    return 4;
      INT16:   return 2;
      default: return 1;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== source/simd_div_slice.sv ====
// Packed-SIMD unsigned integer divide slice with four lanes
`timescale 1ns/1ns
`default_nettype none

module simd_div_slice #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  // Request
  input  logic [simd_div_pkg::SLICE_WIDTH-1:0] operand_a_i,
  input  logic [simd_div_pkg::SLICE_WIDTH-1:0] operand_b_i,
  input  simd_div_pkg::int_fmt_e               fmt_i,
  input  simd_div_pkg::div_op_e                op_i,
  input  logic                                 vectorial_i,
  input  logic [simd_div_pkg::NUM_LANES-1:0]   simd_mask_i,
  input  logic [TagWidth-1:0]                  tag_i,
  input  logic                                 in_valid_i,
  output logic                                 in_ready_o,
  input  logic                                 flush_i,
  // Response
  output logic [simd_div_pkg::SLICE_WIDTH-1:0] result_o,
  output logic                                 status_dz_o,
  output logic [TagWidth-1:0]                  tag_o,
  output logic                                 out_valid_o,
  input  logic                                 out_ready_i,
  output logic                                 busy_o
);

  import simd_div_pkg::*;

  logic start;
  logic step;
  logic last_step;

  logic [NUM_LANES-1:0][SLICE_WIDTH-1:0] lane_dividend;
  logic [NUM_LANES-1:0][SLICE_WIDTH-1:0] lane_divisor;
  logic [NUM_LANES-1:0][SLICE_WIDTH-1:0] lane_quotient;
  logic [NUM_LANES-1:0][SLICE_WIDTH-1:0] lane_remainder;
  logic [NUM_LANES-1:0]                  lane_active;
  logic [NUM_LANES-1:0]                  lane_div_zero;

  // ----------------------------------------------------------
  // Control
  // ----------------------------------------------------------
  simd_div_ctrl simd_div_ctrl_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .flush_i     (flush_i),
    .out_ready_i (out_ready_i),
    .last_step_i (last_step),
    .in_ready_o  (in_ready_o),
    .start_o     (start),
    .step_o      (step),
    .out_valid_o (out_valid_o),
    .busy_o      (busy_o)
  );

  iter_counter iter_counter_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .start_i     (start),
    .step_i      (step),
    .fmt_i       (fmt_i),
    .last_step_o (last_step)
  );

  // ----------------------------------------------------------
  // Lanes
  // ----------------------------------------------------------
  lane_slicer lane_slicer_inst (
    .operand_a_i     (operand_a_i),
    .operand_b_i     (operand_b_i),
    .fmt_i           (fmt_i),
    .vectorial_i     (vectorial_i),
    .lane_dividend_o (lane_dividend),
    .lane_divisor_o  (lane_divisor),
    .lane_active_o   (lane_active)
  );

  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lanes
    localparam int unsigned LW = LANE_WIDTHS[lane];

    logic [LW-1:0] quo;
    logic [LW-1:0] rem;

    div_lane #(
      .LaneWidth (LW)
    ) div_lane_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .start_i     (start),
      .step_i      (step),
      .dividend_i  (lane_dividend[lane]),
      .divisor_i   (lane_divisor[lane]),
      .quotient_o  (quo),
      .remainder_o (rem),
      .div_zero_o  (lane_div_zero[lane])
    );

    // Narrow lanes are zero-extended to a full word for the packer
    assign lane_quotient[lane]  = SLICE_WIDTH'(quo);
    assign lane_remainder[lane] = SLICE_WIDTH'(rem);
  end

  // ----------------------------------------------------------
  // Output side
  // ----------------------------------------------------------
  result_packer #(
    .TagWidth (TagWidth)
  ) result_packer_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .start_i          (start),
    .fmt_i            (fmt_i),
    .op_i             (op_i),
    .simd_mask_i      (simd_mask_i),
    .lane_active_i    (lane_active),
    .tag_i            (tag_i),
    .lane_quotient_i  (lane_quotient),
    .lane_remainder_i (lane_remainder),
    .lane_div_zero_i  (lane_div_zero),
    .result_o         (result_o),
    .status_dz_o      (status_dz_o),
    .tag_o            (tag_o)
  );

endmodule

`default_nettype wire

// ==== verification/simd_div_slice_tb.sv ====
// Directed testbench for the packed-SIMD integer divide slice
`timescale 1ns/1ns
`default_nettype none

module simd_div_slice_tb;

  import simd_div_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  // Up to 40 operations of at most 40 cycles, plus reset and margin
  localparam int WATCHDOG_NS = (40 * 40 + 60) * CLK_PERIOD;

  logic        clk = 1'b0;
  logic        reset;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  int_fmt_e    fmt;
  div_op_e     op;
  logic        vectorial;
  logic [3:0]  simd_mask;
  logic [3:0]  tag_in;
  logic        in_valid;
  logic        in_ready;
  logic        flush;
  logic [31:0] result;
  logic        status_dz;
  logic [3:0]  tag_out;
  logic        out_valid;
  logic        out_ready;
  logic        busy;

  int          error_count  = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  logic [31:0] lfsr_q       = 32'h5f9e;

  always #(CLK_PERIOD / 2) clk = ~clk;

  simd_div_slice #(
    .TagWidth (4)
  ) simd_div_slice_inst (
    .clk_i       (clk),
    .reset_i     (reset),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .fmt_i       (fmt),
    .op_i        (op),
    .vectorial_i (vectorial),
    .simd_mask_i (simd_mask),
    .tag_i       (tag_in),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .flush_i     (flush),
    .result_o    (result),
    .status_dz_o (status_dz),
    .tag_o       (tag_out),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .busy_o      (busy)
  );

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  // Fibonacci LFSR with taps 32 22 2 1, one step per bit
  function automatic logic [31:0] lfsr_bits(int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic int elem_width(int_fmt_e f);
    if (f == INT8) return 8;
    if (f == INT16) return 16;
    return 32;
  endfunction

  // Reference model: unsigned divide per lane field, all ones on a zero divisor
  function automatic void model_op(input logic [31:0] a, input logic [31:0] b,
                                   input int_fmt_e f, input div_op_e o, input logic vec,
                                   input logic [3:0] lane_mask,
                                   output logic [31:0] res, output logic dz);
    int          w;
    int          lanes;
    logic [31:0] fmask;
    logic [31:0] fa;
    logic [31:0] fb;
    logic [31:0] val;
    w     = elem_width(f);
    lanes = vec ? 32 / w : 1;
    fmask = 32'hffff_ffff >> (32 - w);
    res   = '0;
    dz    = 1'b0;
    for (int i = 0; i < lanes; i++) begin
      fa = (a >> (i * w)) & fmask;
      fb = (b >> (i * w)) & fmask;
      if (fb == 0) begin
        val = (o == REM) ? fa : fmask;
        dz  = dz | lane_mask[i];
      end else begin
        val = (o == REM) ? fa % fb : fa / fb;
      end
      res = res | (val << (i * w));
    end
  endfunction

  task automatic tick();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got 0x%08h expected 0x%08h",
               $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  // Sends one request, checks latency and response, then holds back-pressure
  task automatic run_op(input logic [31:0] a, input logic [31:0] b, input int_fmt_e f,
                        input div_op_e o, input logic vec, input logic [3:0] lane_mask,
                        input int hold);
    logic [31:0] exp_res;
    logic        exp_dz;
    logic [3:0]  tg;
    int          edges;
    model_op(a, b, f, o, vec, lane_mask, exp_res, exp_dz);
    tg        = 4'(lfsr_bits(4));
    operand_a = a;
    operand_b = b;
    fmt       = f;
    op        = o;
    vectorial = vec;
    simd_mask = lane_mask;
    tag_in    = tg;
    in_valid  = 1'b1;
    check_value("in_ready before request", in_ready, 1'b1);
    tick();
    in_valid = 1'b0;
    edges    = 0;
    while (!out_valid && edges <= 40) begin
      check_value("busy while running", busy, 1'b1);
      check_value("in_ready while running", in_ready, 1'b0);
      tick();
      edges++;
    end
    if (!out_valid) begin
      $display("Result of a request never became valid within 40 cycles");
      error_count++;
      return;
    end
    check_value("latency in edges", edges, elem_width(f) + 1);
    check_value("result", result, exp_res);
    check_value("status_dz", status_dz, exp_dz);
    check_value("tag", tag_out, tg);
    repeat (hold) begin
      tick();
      check_value("out_valid under back-pressure", out_valid, 1'b1);
      check_value("result under back-pressure", result, exp_res);
      check_value("status_dz under back-pressure", status_dz, exp_dz);
      check_value("tag under back-pressure", tag_out, tg);
      check_value("in_ready under back-pressure", in_ready, 1'b0);
    end
    out_ready = 1'b1;
    tick();
    check_value("out_valid after take", out_valid, 1'b0);
    check_value("in_ready after take", in_ready, 1'b1);
    out_ready = 1'b0;
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic check_reset_state();
    int errs;
    errs = error_count;
    check_value("in_ready after reset", in_ready, 1'b1);
    check_value("out_valid after reset", out_valid, 1'b0);
    check_value("busy after reset", busy, 1'b0);
    report_test("reset state", errs);
  endtask

  task automatic scalar_wide_ops();
    int          errs;
    logic [31:0] a;
    logic [31:0] b;
    errs = error_count;
    repeat (2) begin
      a = lfsr_bits(32);
      b = lfsr_bits(32) >> lfsr_bits(4);
      run_op(a, b, INT32, DIV, 1'b0, 4'hf, 0);
      run_op(a, b, INT32, REM, 1'b0, 4'hf, 0);
    end
    report_test("scalar INT32", errs);
  endtask

  task automatic vector_narrow_ops();
    int          errs;
    logic [31:0] a;
    logic [31:0] b;
    errs = error_count;
    repeat (2) begin
      a = lfsr_bits(32);
      b = lfsr_bits(32);
      run_op(a, b, INT8, DIV, 1'b1, 4'hf, 0);
      run_op(a, b, INT8, REM, 1'b1, 4'hf, 0);
      run_op(a, b, INT16, DIV, 1'b1, 4'hf, 0);
      run_op(a, b, INT16, REM, 1'b1, 4'hf, 0);
    end
    report_test("vectorial INT8 and INT16", errs);
  endtask

  task automatic scalar_narrow_ops();
    int          errs;
    logic [31:0] a;
    logic [31:0] b;
    errs = error_count;
    a    = lfsr_bits(32);
    b    = lfsr_bits(32) | 32'h0001_0001;
    run_op(a, b, INT8, DIV, 1'b0, 4'hf, 0);
    run_op(a, b, INT8, REM, 1'b0, 4'hf, 0);
    run_op(a, b, INT16, DIV, 1'b0, 4'hf, 0);
    run_op(a, b, INT16, REM, 1'b0, 4'hf, 0);
    report_test("scalar INT8 and INT16", errs);
  endtask

  task automatic zero_divisor_ops();
    int          errs;
    logic [31:0] a;
    logic [31:0] b;
    errs = error_count;
    a    = lfsr_bits(32);
    // Bytes 1 and 3 are zero
    b    = {8'h00, 8'(lfsr_bits(8)) | 8'h01, 8'h00, 8'(lfsr_bits(8)) | 8'h01};
    run_op(a, b, INT8, DIV, 1'b1, 4'b1010, 0);
    run_op(a, b, INT8, REM, 1'b1, 4'b0101, 0);
    run_op(a, b, INT8, DIV, 1'b1, 4'b1000, 0);
    // Zero byte 1 sits outside the active lane of a scalar request
    run_op(a, b, INT8, DIV, 1'b0, 4'hf, 0);
    b = {16'h0000, 16'(lfsr_bits(16)) | 16'h0001};
    run_op(a, b, INT16, DIV, 1'b1, 4'b0001, 0);
    run_op(a, b, INT16, REM, 1'b1, 4'b0010, 0);
    run_op(a, 32'h0, INT32, REM, 1'b0, 4'b0001, 0);
    report_test("zero divisor and mask", errs);
  endtask

  task automatic backpressure_and_flush();
    int errs;
    errs = error_count;
    run_op(lfsr_bits(32), lfsr_bits(32), INT16, DIV, 1'b1, 4'hf, 5);
    operand_a = lfsr_bits(32);
    operand_b = 32'd3;
    fmt       = INT32;
    op        = DIV;
    vectorial = 1'b0;
    in_valid  = 1'b1;
    tick();
    in_valid = 1'b0;
    repeat (5) tick();
    check_value("busy before flush", busy, 1'b1);
    flush = 1'b1;
    tick();
    flush = 1'b0;
    check_value("busy after flush", busy, 1'b0);
    check_value("out_valid after flush", out_valid, 1'b0);
    repeat (40) begin
      tick();
      check_value("out_valid stays low after flush", out_valid, 1'b0);
    end
    run_op(lfsr_bits(32), lfsr_bits(32), INT8, REM, 1'b1, 4'hf, 0);
    report_test("back-pressure and flush", errs);
  endtask

  // ----------------------------------------------------------
  // Sequence and watchdog
  // ----------------------------------------------------------
  initial begin
    reset     = 1'b1;
    operand_a = '0;
    operand_b = '0;
    fmt       = INT8;
    op        = DIV;
    vectorial = 1'b0;
    simd_mask = '0;
    tag_in    = '0;
    in_valid  = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b0;
    repeat (8) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    check_reset_state();
    scalar_wide_ops();
    vector_narrow_ops();
    scalar_narrow_ops();
    zero_divisor_ops();
    backpressure_and_flush();
    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #WATCHDOG_NS;
    $display("Watchdog expired before the tests completed");
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
